// File: filelist.f
verilog/raster_pkg.sv
verilog/shape_controller.sv
verilog/line_stepper.sv
verilog/pixel_credit_port.sv
verilog/raster_top.sv
testbench/raster_checker.sv
testbench/raster_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the rasterizer testbench with Verilator, runs it and checks the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module raster_tb -f filelist.f -o raster_sim
./obj_dir/raster_sim | tee sim.log

if grep -qxF '*** PASSED ***' sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed"
	exit 1
fi

// File: testbench/raster_checker.sv
/*
 * Compares every out_pixel with a Bresenham model of the accepted command.
 * Pixels are expected relative to the minimum x and y of the active vertices.
 * Outstanding pixels are counted from out_valid and credit_return.
 */
module raster_checker #(
	parameter int CREDITS = 4
) (
	input  logic                   clk,
	input  logic                   n_rst,
	input  logic                   cmd_valid,
	input  raster_pkg::shape_cmd_t cmd,
	input  logic                   cmd_ready,
	input  logic                   out_valid,
	input  raster_pkg::pixel_t     out_pixel,
	input  logic                   credit_return,
	input  logic                   shape_done,
	input  logic [15:0]            exp_pixels,
	output int                     error_count,
	output int                     pixel_count,
	output int                     shape_count
);
	import raster_pkg::*;

	pixel_t exp_q[$];
	pixel_t exp_pix;
	logic   mark_first;
	logic   in_shape;
	logic   rst_seen;
	logic   burst_seen;
	int     outstanding;
	int     shape_pixels;
	int     want_pixels;

	// Walks one edge, both endpoints included
	task automatic add_edge(input int x0, input int y0, input int x1, input int y1);
		int dx, dy, sx, sy, err, e2, x, y;
		pixel_t p;
		dx  = (x1 > x0) ? x1 - x0 : x0 - x1;
		dy  = (y1 > y0) ? y0 - y1 : y1 - y0;
		sx  = (x1 < x0) ? -1 : 1;
		sy  = (y1 < y0) ? -1 : 1;
		err = dx + dy;
		x   = x0;
		y   = y0;
		forever begin
			p = {coord_t'(x), coord_t'(y), mark_first};
			exp_q.push_back(p);
			mark_first = 1'b0;
			if (x == x1 && y == y1)
				break;
			e2 = 2 * err;
			if (e2 >= dy) begin
				err += dy;
				x += sx;
			end
			if (e2 <= dx) begin
				err += dx;
				y += sy;
			end
		end
	endtask

	task automatic build_shape(input shape_cmd_t c);
		int mx, my;
		mx = (c.v1.x < c.v0.x) ? c.v1.x : c.v0.x;
		my = (c.v1.y < c.v0.y) ? c.v1.y : c.v0.y;
		if (c.kind == SHAPE_TRI) begin
			mx = (c.v2.x < mx) ? c.v2.x : mx;
			my = (c.v2.y < my) ? c.v2.y : my;
		end
		exp_q.delete();
		mark_first = 1'b1;
		add_edge(c.v0.x - mx, c.v0.y - my, c.v1.x - mx, c.v1.y - my);
		if (c.kind == SHAPE_TRI) begin
			add_edge(c.v0.x - mx, c.v0.y - my, c.v2.x - mx, c.v2.y - my);
			add_edge(c.v1.x - mx, c.v1.y - my, c.v2.x - mx, c.v2.y - my);
		end
	endtask

	initial begin
		error_count = 0;
		pixel_count = 0;
		shape_count = 0;
		in_shape    = 1'b0;
		rst_seen    = 1'b0;
	end

	always @(posedge clk) begin
		if (!n_rst) begin
			rst_seen    = 1'b1;
			in_shape    = 1'b0;
			burst_seen  = 1'b0;
			outstanding = 0;
		end else begin
			if (rst_seen && (out_valid !== 1'b0 || shape_done !== 1'b0 || cmd_ready !== 1'b0)) begin
				$display("Error after reset: out_valid %h shape_done %h cmd_ready %h, expected 0",
					out_valid, shape_done, cmd_ready);
				error_count++;
			end
			rst_seen = 1'b0;
			if (out_valid === 1'b1) begin
				pixel_count++;
				outstanding++;
				if (!in_shape || exp_q.size() == 0) begin
					$display("Pixel %h arrived while none was expected", out_pixel);
					error_count++;
				end else begin
					exp_pix = exp_q.pop_front();
					shape_pixels++;
					if (out_pixel !== exp_pix) begin
						$display("Error out_pixel: got %h expected %h", out_pixel, exp_pix);
						error_count++;
					end
				end
			end
			if (credit_return === 1'b1) begin
				// Sink holds back until a full burst has arrived
				if (!burst_seen && outstanding < CREDITS) begin
					$display("Only %0d pixels arrived before the first credit return", outstanding);
					error_count++;
				end
				burst_seen = 1'b1;
				outstanding--;
			end
			if (outstanding > CREDITS) begin
				$display("%0d pixels outstanding with only %0d credits", outstanding, CREDITS);
				error_count++;
			end
			if (in_shape && cmd_ready === 1'b1) begin
				$display("cmd_ready went high while a shape was still in progress");
				error_count++;
			end
			if (shape_done === 1'b1) begin
				if (!in_shape) begin
					$display("shape_done pulsed with no shape in progress");
					error_count++;
				end else begin
					if (exp_q.size() != 0 || shape_pixels != want_pixels) begin
						$display("Error pixel count: got %h expected %h", shape_pixels, want_pixels);
						error_count++;
					end
					in_shape = 1'b0;
					shape_count++;
				end
			end
			if (cmd_valid === 1'b1 && cmd_ready === 1'b1) begin
				build_shape(cmd);
				want_pixels = exp_pixels;
				if (exp_q.size() != want_pixels) begin
					$display("Error exp_pixels: got %h model %h", want_pixels, exp_q.size());
					error_count++;
				end
				shape_pixels = 0;
				in_shape     = 1'b1;
			end
		end
	end

endmodule

// File: testbench/raster_tb.sv
/*
 * Testbench for raster_top. Commands come from testbench/raster_vectors.txt,
 * read relative to the project root, at most MAX_VEC of them.
 * The sink returns credits after a random hold, with occasional long stalls.
 */
module raster_tb;
	import raster_pkg::*;

	localparam int CREDITS     = 4;
	localparam int MAX_VEC     = 64;
	localparam int VEC_W       = 8;
	localparam int CYC_PER_VEC = 2000;
	localparam int BURST_WAIT  = 4 * CREDITS + 8;

	logic        clk;
	logic        n_rst;
	logic        cmd_valid;
	shape_cmd_t  cmd;
	logic        cmd_ready;
	logic        out_valid;
	pixel_t      out_pixel;
	logic        credit_return;
	logic        shape_done;
	logic [15:0] exp_pixels;
	logic [15:0] vec_mem [MAX_VEC*VEC_W];
	logic        loaded;
	int          num_vec;
	int          held;
	int          error_count;
	int          pixel_count;
	int          shape_count;

	raster_top #(
		.CREDITS (CREDITS)
	) dut_i (
		.clk           (clk),
		.n_rst         (n_rst),
		.cmd_valid     (cmd_valid),
		.cmd           (cmd),
		.cmd_ready     (cmd_ready),
		.out_valid     (out_valid),
		.out_pixel     (out_pixel),
		.credit_return (credit_return),
		.shape_done    (shape_done)
	);

	raster_checker #(
		.CREDITS (CREDITS)
	) checker_i (
		.clk           (clk),
		.n_rst         (n_rst),
		.cmd_valid     (cmd_valid),
		.cmd           (cmd),
		.cmd_ready     (cmd_ready),
		.out_valid     (out_valid),
		.out_pixel     (out_pixel),
		.credit_return (credit_return),
		.shape_done    (shape_done),
		.exp_pixels    (exp_pixels),
		.error_count   (error_count),
		.pixel_count   (pixel_count),
		.shape_count   (shape_count)
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Unused words keep an address pattern, so a kind above 1 ends the list
	task automatic load_vectors();
		for (int i = 0; i < MAX_VEC * VEC_W; i++)
			vec_mem[i] = 16'h8000 | 16'(i);
		$readmemh("testbench/raster_vectors.txt", vec_mem);
		num_vec = 0;
		while (num_vec < MAX_VEC && vec_mem[num_vec*VEC_W] <= 16'h0001)
			num_vec++;
	endtask

	task automatic send_shape(input int base);
		while (cmd_ready !== 1'b1) begin
			@(posedge clk);
			#10;
		end
		cmd.kind = shape_kind_e'(vec_mem[base][0]);
		cmd.v0   = {vec_mem[base+1][7:0], vec_mem[base+2][7:0]};
		cmd.v1   = {vec_mem[base+3][7:0], vec_mem[base+4][7:0]};
		cmd.v2   = {vec_mem[base+5][7:0], vec_mem[base+6][7:0]};
		// v2 of a line should be ignored
		if (cmd.kind == SHAPE_LINE)
			cmd.v2 = 16'($urandom);
		exp_pixels = vec_mem[base+7];
		cmd_valid  = 1'b1;
		@(posedge clk);
		#10;
		cmd_valid = 1'b0;
	endtask

	initial begin
		int gap;
		void'($urandom(85));
		n_rst      = 1'b0;
		cmd_valid  = 1'b0;
		cmd        = '0;
		exp_pixels = '0;
		loaded     = 1'b0;
		load_vectors();
		loaded = 1'b1;
		if (num_vec == 0)
			$display("No vectors were read from the vector file");
		repeat (5) @(posedge clk);
		#10;
		n_rst = 1'b1;
		for (int i = 0; i < num_vec; i++) begin
			gap = $urandom % 3;
			repeat (gap) begin
				@(posedge clk);
				#10;
			end
			send_shape(i * VEC_W);
		end
		// Last shape finished and every credit back
		while (cmd_ready !== 1'b1 || held != 0) begin
			@(posedge clk);
			#40;
		end
		repeat (2) @(posedge clk);
		#10;
		$display("Shapes %0d of %0d, pixels %0d, errors %0d",
			shape_count, num_vec, pixel_count, error_count);
		if (error_count == 0 && shape_count == num_vec && num_vec > 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

	// Sink model
	initial begin
		int   delay;
		int   stall;
		int   burst_wait;
		logic burst_done;
		credit_return = 1'b0;
		held          = 0;
		delay         = 0;
		stall         = 0;
		burst_wait    = 0;
		burst_done    = 1'b0;
		forever begin
			@(posedge clk);
			#10;
			credit_return = 1'b0;
			if (out_valid === 1'b1)
				held++;
			// A short first burst ends after BURST_WAIT cycles
			if (held > 0 && !burst_done)
				burst_wait++;
			if (held >= CREDITS || burst_wait > BURST_WAIT)
				burst_done = 1'b1;
			if (stall > 0)
				stall--;
			else if ($urandom % 64 == 0)
				stall = 30 + $urandom % 31;
			else if (delay > 0)
				delay--;
			else if (burst_done && held > 0) begin
				credit_return = 1'b1;
				held--;
				delay = $urandom % 4;
			end
		end
	end

	initial begin
		int limit;
		wait (loaded === 1'b1);
		limit = (num_vec > 0) ? num_vec * CYC_PER_VEC : CYC_PER_VEC;
		repeat (limit) @(posedge clk);
		$display("Timeout, the run did not finish within %0d cycles", limit);
		$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: testbench/raster_vectors.txt
// One command per line, all hex: kind (0 line, 1 triangle) v0x v0y v1x v1y v2x v2y
// then the expected pixel count of the whole shape; v2 of a line is not used
0 0a 14 11 17 00 00 0008
0 0a 14 0d 1d 00 00 000a
0 32 0a 2f 10 00 00 0007
0 32 0a 29 0e 00 00 000a
0 3c 3c 34 39 00 00 0009
0 3c 3c 3a 33 00 00 000a
0 05 28 09 21 00 00 0008
0 05 28 10 23 00 00 000c
0 64 07 5a 07 00 00 000b
0 03 c8 03 d4 00 00 000d
0 4d 4d 4d 4d 00 00 0001
0 00 00 06 06 00 00 0007
1 0a 0a 14 0e 0d 19 0027
1 c8 64 b4 5a d2 46 0053
1 05 05 05 05 05 05 0003
0 00 00 ff 64 00 00 0100

// File: verilog/line_stepper.sv
/*
 * Integer Bresenham walk over one edge, both endpoints included.
 * One pixel per cycle while can_send is high; position holds otherwise.
 * A new edge_start is expected only after edge_done of the previous edge.
 */
module line_stepper (
	input  logic               clk,
	input  logic               n_rst,
	input  logic               edge_start,
	input  raster_pkg::edge_t  edge_pts,
	input  logic               first_edge,
	input  logic               can_send,
	output logic               pix_push,
	output raster_pkg::pixel_t pix,
	output logic               edge_done
);
	import raster_pkg::*;

	logic               busy;
	logic               first_pend;
	coord_t             cur_x;
	coord_t             cur_y;
	coord_t             end_x;
	coord_t             end_y;
	coord_t             adx;
	coord_t             ady;
	logic               x_neg;
	logic               y_neg;
	logic signed [8:0]  dx;
	logic signed [8:0]  dy;
	logic signed [10:0] err;
	logic signed [10:0] err_nxt;
	logic signed [11:0] e2;
	logic               step_x;
	logic               step_y;
	logic               at_end;

	// Absolute deltas of the incoming edge
	assign adx = (edge_pts.end_pt.x >= edge_pts.start_pt.x) ?
		edge_pts.end_pt.x - edge_pts.start_pt.x : edge_pts.start_pt.x - edge_pts.end_pt.x;
	assign ady = (edge_pts.end_pt.y >= edge_pts.start_pt.y) ?
		edge_pts.end_pt.y - edge_pts.start_pt.y : edge_pts.start_pt.y - edge_pts.end_pt.y;

	assign e2     = {err, 1'b0};
	assign step_x = (e2 >= dy);
	assign step_y = (e2 <= dx);
	assign at_end = (cur_x == end_x) && (cur_y == end_y);

	always_comb begin
		err_nxt = err;
		if (step_x)
			err_nxt = err_nxt + dy;
		if (step_y)
			err_nxt = err_nxt + dx;
	end

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			busy       <= 1'b0;
			first_pend <= 1'b0;
		end else if (edge_start) begin
			busy       <= 1'b1;
			first_pend <= first_edge;
		end else if (pix_push) begin
			first_pend <= 1'b0;
			if (at_end)
				busy <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (edge_start) begin
			cur_x <= edge_pts.start_pt.x;
			cur_y <= edge_pts.start_pt.y;
			end_x <= edge_pts.end_pt.x;
			end_y <= edge_pts.end_pt.y;
			x_neg <= (edge_pts.end_pt.x < edge_pts.start_pt.x);
			y_neg <= (edge_pts.end_pt.y < edge_pts.start_pt.y);
			dx    <= $signed({1'b0, adx});
			dy    <= -$signed({1'b0, ady});
			err   <= $signed({1'b0, adx}) - $signed({1'b0, ady});
		end else if (pix_push && !at_end) begin
			if (step_x)
				cur_x <= x_neg ? cur_x - 8'd1 : cur_x + 8'd1;
			if (step_y)
				cur_y <= y_neg ? cur_y - 8'd1 : cur_y + 8'd1;
			err <= err_nxt;
		end
	end

	assign pix_push  = busy && can_send;
	assign edge_done = pix_push && at_end;

	always_comb begin
		pix.x     = cur_x;
		pix.y     = cur_y;
		pix.first = first_pend;
	end

endmodule

// File: verilog/pixel_credit_port.sv
/*
 * Credit-based pixel output, CREDITS from 1 to 15.
 * Returns beyond CREDITS are dropped. A push and a return together cancel.
 */
module pixel_credit_port #(
	parameter int CREDITS = 4
) (
	input  logic               clk,
	input  logic               n_rst,
	input  logic               pix_push,
	input  raster_pkg::pixel_t pix,
	output logic               can_send,
	output logic               out_valid,
	output raster_pkg::pixel_t out_pixel,
	input  logic               credit_return
);
	localparam int CNT_W = $clog2(CREDITS + 1);

	logic [CNT_W-1:0] credits;
	logic             at_max;

	assign at_max   = (credits == CNT_W'(CREDITS));
	assign can_send = (credits != '0);

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			credits   <= CNT_W'(CREDITS);
			out_valid <= 1'b0;
		end else begin
			out_valid <= pix_push;
			if (pix_push && !credit_return)
				credits <= credits - 1'b1;
			else if (credit_return && !pix_push && !at_max)
				credits <= credits + 1'b1;
		end
	end

	// Output register holds the pixel for the strobe cycle
	always_ff @(posedge clk) begin
		if (pix_push)
			out_pixel <= pix;
	end

endmodule

// File: verilog/raster_pkg.sv
/*
 * Shared types for the line and triangle rasterizer.
 * Coordinates are unsigned and wrap at COORD_W bits, with no clipping.
 */
package raster_pkg;

	localparam int COORD_W = 8;

	typedef logic [COORD_W-1:0] coord_t;

	typedef enum logic [0:0] {
		SHAPE_LINE,
		SHAPE_TRI
	} shape_kind_e;

	typedef struct packed {
		coord_t x;
		coord_t y;
	} vertex_t;

	// v2 only matters for a triangle
	typedef struct packed {
		shape_kind_e kind;
		vertex_t     v0;
		vertex_t     v1;
		vertex_t     v2;
	} shape_cmd_t;

	// Endpoints already shifted into the local tile
	typedef struct packed {
		vertex_t start_pt;
		vertex_t end_pt;
	} edge_t;

	typedef struct packed {
		coord_t x;
		coord_t y;
		logic   first;
	} pixel_t;

	typedef enum logic [2:0] {
		IDLE,
		MIN_CALC,
		EDGE_START,
		EDGE_WAIT,
		DONE
	} ctrl_state_e;

endpackage

// File: verilog/raster_top.sv
/*
 * Line and triangle rasterizer, one shape in flight at a time.
 * Pixels come out relative to the shape's minimum x and y.
 */
module raster_top #(
	parameter int CREDITS = 4
) (
	input  logic                   clk,
	input  logic                   n_rst,
	input  logic                   cmd_valid,
	input  raster_pkg::shape_cmd_t cmd,
	output logic                   cmd_ready,
	output logic                   out_valid,
	output raster_pkg::pixel_t     out_pixel,
	input  logic                   credit_return,
	output logic                   shape_done
);
	import raster_pkg::*;

	logic   edge_start;
	edge_t  edge_pts;
	logic   first_edge;
	logic   edge_done;
	logic   can_send;
	logic   pix_push;
	pixel_t pix;

	shape_controller ctrl_i (
		.clk        (clk),
		.n_rst      (n_rst),
		.cmd_valid  (cmd_valid),
		.cmd        (cmd),
		.cmd_ready  (cmd_ready),
		.edge_start (edge_start),
		.edge_pts   (edge_pts),
		.first_edge (first_edge),
		.edge_done  (edge_done),
		.shape_done (shape_done)
	);

	line_stepper step_i (
		.clk        (clk),
		.n_rst      (n_rst),
		.edge_start (edge_start),
		.edge_pts   (edge_pts),
		.first_edge (first_edge),
		.can_send   (can_send),
		.pix_push   (pix_push),
		.pix        (pix),
		.edge_done  (edge_done)
	);

	pixel_credit_port #(
		.CREDITS (CREDITS)
	) port_i (
		.clk           (clk),
		.n_rst         (n_rst),
		.pix_push      (pix_push),
		.pix           (pix),
		.can_send      (can_send),
		.out_valid     (out_valid),
		.out_pixel     (out_pixel),
		.credit_return (credit_return)
	);

endmodule

// File: verilog/shape_controller.sv
/*
 * Takes one shape command at a time and feeds its edges to the stepper.
 * A new command is refused until shape_done of the current one.
 * Edge order is v0-v1, then v0-v2 and v1-v2 for a triangle.
 */
module shape_controller (
	input  logic                   clk,
	input  logic                   n_rst,
	input  logic                   cmd_valid,
	input  raster_pkg::shape_cmd_t cmd,
	output logic                   cmd_ready,
	output logic                   edge_start,
	output raster_pkg::edge_t      edge_pts,
	output logic                   first_edge,
	input  logic                   edge_done,
	output logic                   shape_done
);
	import raster_pkg::*;

	ctrl_state_e state;
	ctrl_state_e next_state;
	shape_cmd_t  cmd_q;
	coord_t      min_x;
	coord_t      min_y;
	coord_t      min_x_c;
	coord_t      min_y_c;
	logic [1:0]  edge_idx;
	logic        last_edge;
	logic        accept;
	vertex_t     pa;
	vertex_t     pb;

	function automatic vertex_t offset(input vertex_t v, input coord_t mx, input coord_t my);
		vertex_t r;
		r.x = v.x - mx;
		r.y = v.y - my;
		return r;
	endfunction

	assign accept = cmd_valid && cmd_ready;

	always_ff @(posedge clk, negedge n_rst) begin
		if (!n_rst) begin
			state     <= IDLE;
			cmd_ready <= 1'b0;
			edge_idx  <= '0;
		end else begin
			state     <= next_state;
			cmd_ready <= (next_state == IDLE);
			if (state == MIN_CALC)
				edge_idx <= '0;
			else if (state == EDGE_WAIT && edge_done)
				edge_idx <= edge_idx + 2'd1;
		end
	end

	always_ff @(posedge clk) begin
		if (accept)
			cmd_q <= cmd;
		if (state == MIN_CALC) begin
			min_x <= min_x_c;
			min_y <= min_y_c;
		end
	end

	// Minima over the active vertices
	always_comb begin
		min_x_c = (cmd_q.v1.x < cmd_q.v0.x) ? cmd_q.v1.x : cmd_q.v0.x;
		min_y_c = (cmd_q.v1.y < cmd_q.v0.y) ? cmd_q.v1.y : cmd_q.v0.y;
		if (cmd_q.kind == SHAPE_TRI) begin
			if (cmd_q.v2.x < min_x_c)
				min_x_c = cmd_q.v2.x;
			if (cmd_q.v2.y < min_y_c)
				min_y_c = cmd_q.v2.y;
		end
	end

	always_comb begin
		case (edge_idx)
			2'd0: begin
				pa = cmd_q.v0;
				pb = cmd_q.v1;
			end
			2'd1: begin
				pa = cmd_q.v0;
				pb = cmd_q.v2;
			end
			default: begin
				pa = cmd_q.v1;
				pb = cmd_q.v2;
			end
		endcase
	end

	always_comb begin
		edge_pts.start_pt = offset(pa, min_x, min_y);
		edge_pts.end_pt   = offset(pb, min_x, min_y);
	end

	assign last_edge = (cmd_q.kind == SHAPE_LINE) ? (edge_idx == 2'd0) : (edge_idx == 2'd2);

	always_comb begin
		next_state = state;
		case (state)
			IDLE: begin
				if (accept)
					next_state = MIN_CALC;
			end
			MIN_CALC:
				next_state = EDGE_START;
			EDGE_START:
				next_state = EDGE_WAIT;
			EDGE_WAIT: begin
				if (edge_done)
					next_state = last_edge ? DONE : EDGE_START;
			end
			DONE:
				next_state = IDLE;
			default:
				next_state = IDLE;
		endcase
	end

	assign edge_start = (state == EDGE_START);
	assign first_edge = (edge_idx == 2'd0);
	assign shape_done = (state == DONE);

endmodule
